/* Bender.yml */
package:
  name: usb_phy

export_include_dirs:
  - src

sources:
  - files:
      - src/usb_line_pkg.sv
      - src/usb_data_pkg.sv
      - src/usb_line_filter.sv
      - src/usb_tx_serializer.sv
      - src/usb_rx_deserializer.sv
      - src/usb_phy.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/usb_phy_tb.sv

/* sim.f */
+incdir+src
src/usb_line_pkg.sv
src/usb_data_pkg.sv
src/usb_line_filter.sv
src/usb_tx_serializer.sv
src/usb_rx_deserializer.sv
src/usb_phy.sv
tests/usb_phy_tb.sv

/* src/usb_data_pkg.sv */
// data-side types: the byte type and the transmit and receive state machine encodings
`default_nettype none

package usb_data_pkg;

	// one byte as exchanged with the link layer, sent LSB first
	typedef logic [7:0] usb_byte_t;

	// transmit sequencer
	// idle leaves the bus undriven, data shifts bytes out,
	// then two bit times of SE0 and one bit time of J close the packet
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_EOP_SE0,
		TX_EOP_J
	} tx_state_t;

	// receive sequencer
	// hunt waits for the first K, sync checks the KJKJKJKK pattern,
	// data assembles bytes and done waits for the EOP to finish
	typedef enum logic [1:0] {
		RX_HUNT,
		RX_SYNC,
		RX_DATA,
		RX_DONE
	} rx_state_t;

endpackage

`default_nettype wire

/* src/usb_line_filter.sv */
// two-stage synchronizer and majority glitch filter for the rcv, vp and vm lines of one port
`default_nettype none
`include "usb_phy_config.svh"

module usb_line_filter (
	input  logic usb_clk,
	input  logic usb_rst,
	input  logic rcv,
	input  logic vp,
	input  logic vm,
	output logic rcv_s,
	output logic vp_s,
	output logic vm_s
);
	localparam int DEPTH = `USB_FILTER_DEPTH;

	// first flop of the synchronizer, lanes packed as {rcv, vp, vm}
	logic [2:0] meta;
	// win[0] is the second synchronizer flop and also the newest vote sample
	logic [2:0] win [DEPTH];
	logic [2:0] maj;

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			meta <= '0;
			for (int d = 0; d < DEPTH; d++)
				win[d] <= '0;
		end else begin
			meta <= {rcv, vp, vm};
			win[0] <= meta;
			for (int d = 1; d < DEPTH; d++)
				win[d] <= win[d-1];
		end
	end

	// each lane follows the majority of its window, a one-cycle spike never wins
	for (genvar l = 0; l < 3; l++) begin : g_vote
		logic [DEPTH-1:0] taps;
		for (genvar d = 0; d < DEPTH; d++) begin : g_tap
			assign taps[d] = win[d][l];
		end
		assign maj[l] = $countones(taps) > DEPTH / 2;
	end

	assign {rcv_s, vp_s, vm_s} = maj;

	// the pipeline is flushed by reset, so pins cannot reach the outputs right away
	a_quiet_after_reset: assert property (@(posedge usb_clk)
		$fell(usb_rst) |=> $stable({rcv_s, vp_s, vm_s}))
		else $error("filter output moved right after reset release");

endmodule

`default_nettype wire

/* src/usb_line_pkg.sv */
// bus-side types: line state encoding, port mask and bit-time counter
`default_nettype none

package usb_line_pkg;

	// width of the bit-time counter, enough to count one low-speed bit
	localparam int BIT_DIV_W = 5;

	// line state as seen on the wire, packed as {vm, vp}
	typedef logic [1:0] line_state_t;

	// single-ended zero, both lines low
	localparam line_state_t LS_SE0 = 2'd0;
	// D+ high, which is J at full speed and K at low speed
	localparam line_state_t LS_FS_J = 2'd1;
	// D- high, which is K at full speed and J at low speed
	localparam line_state_t LS_FS_K = 2'd2;

	// one bit per port, bit 0 is port A and bit 1 is port B
	typedef logic [1:0] port_mask_t;

	// counts clocks inside one bit time
	typedef logic [BIT_DIV_W-1:0] bit_div_t;

endpackage

`default_nettype wire

/* src/usb_phy.sv */
// two-port USB 1.1 host PHY top with filters, serializer, deserializer and tri-state drivers
`default_nettype none
`include "usb_phy_config.svh"

module usb_phy (
	input  logic                      usb_clk,
	input  logic                      usb_rst,
	input  logic                      usba_rcv,
	input  logic                      usbb_rcv,
	input  logic                      port_sel_rx,
	input  usb_line_pkg::port_mask_t  port_sel_tx,
	input  usb_data_pkg::usb_byte_t   tx_data,
	input  logic                      tx_valid,
	input  usb_line_pkg::port_mask_t  generate_reset,
	input  logic                      tx_low_speed,
	input  usb_line_pkg::port_mask_t  low_speed,
	input  logic                      generate_eop,
	inout  wire                       usba_vp,
	inout  wire                       usba_vm,
	inout  wire                       usbb_vp,
	inout  wire                       usbb_vm,
	output logic                      usba_spd,
	output logic                      usba_oe_n,
	output logic                      usbb_spd,
	output logic                      usbb_oe_n,
	output usb_line_pkg::line_state_t line_state_a,
	output usb_line_pkg::line_state_t line_state_b,
	output logic                      tx_ready,
	output logic                      tx_busy,
	output usb_data_pkg::usb_byte_t   rx_data,
	output logic                      rx_valid,
	output logic                      rx_active,
	output logic                      rx_error
);
	localparam int BLANK_W = $clog2(`USB_RX_BLANK + 1);

	logic rcv_s_a;
	logic vp_s_a;
	logic vm_s_a;
	logic rcv_s_b;
	logic vp_s_b;
	logic vm_s_b;
	logic txp;
	logic txm;
	logic txoe;
	logic txoe_r;
	logic oe_a;
	logic oe_b;
	logic sel_oe;
	logic rx_reset;
	logic [BLANK_W-1:0] blank_cnt;

	usb_line_filter filter_a (.usb_clk, .usb_rst, .rcv(usba_rcv), .vp(usba_vp), .vm(usba_vm),
		.rcv_s(rcv_s_a), .vp_s(vp_s_a), .vm_s(vm_s_a));
	usb_line_filter filter_b (.usb_clk, .usb_rst, .rcv(usbb_rcv), .vp(usbb_vp), .vm(usbb_vm),
		.rcv_s(rcv_s_b), .vp_s(vp_s_b), .vm_s(vm_s_b));

	assign line_state_a = {vm_s_a, vp_s_a};
	assign line_state_b = {vm_s_b, vp_s_b};

	usb_tx_serializer tx_inst (.usb_clk, .usb_rst, .tx_data, .tx_valid, .low_speed(tx_low_speed),
		.generate_eop, .tx_ready, .txp, .txm, .txoe);

	// busy from the request until the cycle after the bus is released
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txoe_r <= 1'b0;
			tx_busy <= 1'b0;
		end else begin
			txoe_r <= txoe;
			if (tx_valid || generate_eop)
				tx_busy <= 1'b1;
			else if (txoe_r && !txoe)
				tx_busy <= 1'b0;
		end
	end

	// ============================================================
	// drivers, a bus reset overrides the serializer with SE0
	// ============================================================

	assign oe_a = (txoe && port_sel_tx[0]) || generate_reset[0];
	assign oe_b = (txoe && port_sel_tx[1]) || generate_reset[1];
	assign usba_oe_n = !oe_a;
	assign usbb_oe_n = !oe_b;
	assign usba_vp = oe_a ? (!generate_reset[0] && txp) : 1'bz;
	assign usba_vm = oe_a ? (!generate_reset[0] && txm) : 1'bz;
	assign usbb_vp = oe_b ? (!generate_reset[1] && txp) : 1'bz;
	assign usbb_vm = oe_b ? (!generate_reset[1] && txm) : 1'bz;
	assign usba_spd = !low_speed[0];
	assign usbb_spd = !low_speed[1];

	// only the port being listened to blanks the receiver, the other can carry our own traffic
	assign sel_oe = port_sel_rx ? oe_b : oe_a;
	always_ff @(posedge usb_clk) begin
		if (usb_rst)
			blank_cnt <= '0;
		else if (sel_oe)
			blank_cnt <= BLANK_W'(`USB_RX_BLANK);
		else if (blank_cnt != '0)
			blank_cnt <= blank_cnt - 1'b1;
	end
	assign rx_reset = usb_rst || sel_oe || (blank_cnt != '0);

	usb_rx_deserializer rx_inst (.usb_clk, .rx_reset,
		.rx(port_sel_rx ? rcv_s_b : rcv_s_a), .rxp(port_sel_rx ? vp_s_b : vp_s_a),
		.rxm(port_sel_rx ? vm_s_b : vm_s_a), .low_speed(port_sel_rx ? low_speed[1] : low_speed[0]),
		.rx_data, .rx_valid, .rx_active, .rx_error);

	a_one_tx_port: assert property (@(posedge usb_clk) disable iff (usb_rst)
		txoe |-> (port_sel_tx != 2'b11))
		else $error("transmit selects both ports");

endmodule

`default_nettype wire

/* src/usb_phy_config.svh */
// bit-time divisors, glitch filter depth, receiver blanking and bit stuffing limit
`ifndef USB_PHY_CONFIG_SVH
`define USB_PHY_CONFIG_SVH

// ============================================================
// bit timing at a 48 MHz usb_clk
// ============================================================

// full speed runs at 12 Mbit/s, so four clocks make one bit
`define USB_FS_DIV 4

// low speed runs at 1.5 Mbit/s, so one bit lasts 32 clocks
`define USB_LS_DIV 32

// ============================================================
// line conditioning
// ============================================================

// number of synchronized samples the majority vote looks at
`define USB_FILTER_DEPTH 3

// extra cycles the receiver stays in reset once its port stops driving
`define USB_RX_BLANK 3

// after this many ones in a row a zero goes onto the wire
`define USB_STUFF_LIMIT 6

`endif

/* src/usb_rx_deserializer.sv */
// receiver with edge-aligned bit sampling, SYNC hunt, NRZI decoding, destuffing and byte assembly
`default_nettype none
`include "usb_phy_config.svh"

module usb_rx_deserializer (
	input  logic                    usb_clk,
	input  logic                    rx_reset,
	input  logic                    rx,
	input  logic                    rxp,
	input  logic                    rxm,
	input  logic                    low_speed,
	output usb_data_pkg::usb_byte_t rx_data,
	output logic                    rx_valid,
	output logic                    rx_active,
	output logic                    rx_error
);
	usb_data_pkg::rx_state_t state;
	usb_line_pkg::bit_div_t  div_cnt;
	usb_line_pkg::bit_div_t  div_max;
	usb_line_pkg::bit_div_t  div_mid;
	logic       rx_d;
	logic       prev_j;
	logic [2:0] run;
	logic [2:0] bit_cnt;
	logic       se0_seen;
	logic       rx_edge;
	logic       sample;
	logic       se0;
	logic       j_level;
	logic       bit_one;
	logic       data_bit;

	// ============================================================
	// bit recovery
	// ============================================================

	assign div_max = low_speed ? usb_line_pkg::bit_div_t'(`USB_LS_DIV - 1)
	                           : usb_line_pkg::bit_div_t'(`USB_FS_DIV - 1);
	assign div_mid = low_speed ? usb_line_pkg::bit_div_t'(`USB_LS_DIV / 2 - 1)
	                           : usb_line_pkg::bit_div_t'(`USB_FS_DIV / 2 - 1);

	// every transition restarts the timer so the sample lands mid-bit
	assign rx_edge = rx != rx_d;
	assign sample = !rx_edge && (div_cnt == div_mid);
	assign se0 = {rxm, rxp} == usb_line_pkg::LS_SE0;
	assign j_level = rx ^ low_speed;
	// NRZI, an unchanged level is a one
	assign bit_one = j_level == prev_j;
	// a zero that follows the stuffing limit is dropped and never reaches the byte
	assign data_bit = sample && (state == usb_data_pkg::RX_DATA) && !se0 &&
	                  (run != 3'(`USB_STUFF_LIMIT));

	// rx_data is the shift register itself, it only holds still around the strobe
	always_ff @(posedge usb_clk) begin
		rx_d <= rx;
		if (data_bit)
			rx_data <= {bit_one, rx_data[7:1]};
	end

	// ============================================================
	// packet sequencer
	// ============================================================

	always_ff @(posedge usb_clk) begin
		if (rx_reset) begin
			state <= usb_data_pkg::RX_HUNT;
			div_cnt <= '0;
			prev_j <= 1'b1;
			run <= '0;
			bit_cnt <= '0;
			se0_seen <= 1'b0;
			rx_valid <= 1'b0;
			rx_active <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
			div_cnt <= (rx_edge || div_cnt == div_max) ? '0 : div_cnt + 1'b1;
			if (sample)
				prev_j <= j_level;
			case (state)
				usb_data_pkg::RX_HUNT: if (sample && !se0 && !j_level) begin
					// first K of SYNC, count the alternations that follow
					run <= '0;
					state <= usb_data_pkg::RX_SYNC;
				end
				usb_data_pkg::RX_SYNC: if (se0) begin
					state <= usb_data_pkg::RX_HUNT;
				end else if (sample) begin
					if (!bit_one) begin
						run <= (run == 3'd7) ? run : run + 3'd1;
					end else if (run >= 3'd4) begin
						// the closing KK is a one and counts toward stuffing
						run <= 3'd1;
						bit_cnt <= '0;
						rx_active <= 1'b1;
						state <= usb_data_pkg::RX_DATA;
					end else begin
						state <= usb_data_pkg::RX_HUNT;
					end
				end
				usb_data_pkg::RX_DATA: if (se0) begin
					// EOP inside a byte is an error
					rx_error <= bit_cnt != 3'd0;
					se0_seen <= 1'b1;
					state <= usb_data_pkg::RX_DONE;
				end else if (sample) begin
					if (run == 3'(`USB_STUFF_LIMIT)) begin
						run <= '0;
						if (bit_one) begin
							rx_error <= 1'b1;
							se0_seen <= 1'b0;
							state <= usb_data_pkg::RX_DONE;
						end
					end else begin
						run <= bit_one ? run + 3'd1 : 3'd0;
						bit_cnt <= bit_cnt + 3'd1;
						rx_valid <= bit_cnt == 3'd7;
					end
				end
				usb_data_pkg::RX_DONE: if (se0) begin
					se0_seen <= 1'b1;
				end else if (se0_seen) begin
					rx_active <= 1'b0;
					state <= usb_data_pkg::RX_HUNT;
				end
				default: state <= usb_data_pkg::RX_HUNT;
			endcase
		end
	end

	a_valid_in_packet: assert property (@(posedge usb_clk) disable iff (rx_reset)
		rx_valid |-> rx_active)
		else $error("rx_valid outside a packet");

	a_error_excl_valid: assert property (@(posedge usb_clk) disable iff (rx_reset)
		!(rx_error && rx_valid))
		else $error("rx_error and rx_valid in the same cycle");

endmodule

`default_nettype wire

/* src/usb_tx_serializer.sv */
// byte serializer with bit stuffing, NRZI encoding, EOP generation and the byte handshake
`default_nettype none
`include "usb_phy_config.svh"

module usb_tx_serializer (
	input  logic                    usb_clk,
	input  logic                    usb_rst,
	input  usb_data_pkg::usb_byte_t tx_data,
	input  logic                    tx_valid,
	input  logic                    low_speed,
	input  logic                    generate_eop,
	output logic                    tx_ready,
	output logic                    txp,
	output logic                    txm,
	output logic                    txoe
);
	usb_data_pkg::tx_state_t state;
	usb_line_pkg::bit_div_t  div_cnt;
	usb_line_pkg::bit_div_t  div_max;
	usb_data_pkg::usb_byte_t shreg;
	logic [2:0] bit_cnt;
	logic [2:0] ones;
	logic       have_byte;
	logic       eop_half;
	logic       level_j;
	logic       bit_tick;
	logic       stuff;
	logic       shift;
	logic       load;

	// ============================================================
	// bit timing and byte handshake
	// ============================================================

	assign div_max = low_speed ? usb_line_pkg::bit_div_t'(`USB_LS_DIV - 1)
	                           : usb_line_pkg::bit_div_t'(`USB_FS_DIV - 1);
	assign bit_tick = (state != usb_data_pkg::TX_IDLE) && (div_cnt == div_max);

	// a run of ones at the limit takes the next bit slot for a stuffed zero
	assign stuff = ones == 3'(`USB_STUFF_LIMIT);
	assign shift = (state == usb_data_pkg::TX_DATA) && bit_tick && !stuff && have_byte;

	// take a new byte from idle, or right as the last bit of the current one goes out
	assign load = ((state == usb_data_pkg::TX_IDLE) && tx_valid) ||
	              (shift && (bit_cnt == 3'd7) && tx_valid);

	always_ff @(posedge usb_clk) begin
		if (load)
			shreg <= tx_data;
		else if (shift)
			shreg <= shreg >> 1;
	end

	// ============================================================
	// sequencer
	// ============================================================

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state <= usb_data_pkg::TX_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			ones <= '0;
			have_byte <= 1'b0;
			eop_half <= 1'b0;
			level_j <= 1'b1;
			tx_ready <= 1'b0;
		end else begin
			tx_ready <= load;
			div_cnt <= (state == usb_data_pkg::TX_IDLE || bit_tick) ? '0 : div_cnt + 1'b1;
			case (state)
				usb_data_pkg::TX_IDLE: begin
					level_j <= 1'b1;
					ones <= '0;
					bit_cnt <= '0;
					eop_half <= 1'b0;
					// the first bit period after a load keeps the line at J
					if (tx_valid) begin
						have_byte <= 1'b1;
						state <= usb_data_pkg::TX_DATA;
					end else if (generate_eop) begin
						state <= usb_data_pkg::TX_EOP_SE0;
					end
				end
				usb_data_pkg::TX_DATA: if (bit_tick) begin
					if (stuff) begin
						level_j <= ~level_j;
						ones <= '0;
					end else if (have_byte) begin
						// NRZI, a zero flips the line and a one holds it
						if (shreg[0]) begin
							ones <= ones + 3'd1;
						end else begin
							ones <= '0;
							level_j <= ~level_j;
						end
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7 && !tx_valid)
							have_byte <= 1'b0;
					end else begin
						state <= usb_data_pkg::TX_EOP_SE0;
					end
				end
				usb_data_pkg::TX_EOP_SE0: begin
					level_j <= 1'b1;
					if (bit_tick) begin
						eop_half <= 1'b1;
						if (eop_half)
							state <= usb_data_pkg::TX_EOP_J;
					end
				end
				usb_data_pkg::TX_EOP_J: if (bit_tick)
					state <= usb_data_pkg::TX_IDLE;
				default: state <= usb_data_pkg::TX_IDLE;
			endcase
		end
	end

	// low speed swaps the J and K pin levels
	assign txoe = state != usb_data_pkg::TX_IDLE;
	assign {txm, txp} = (state == usb_data_pkg::TX_EOP_SE0) ? usb_line_pkg::LS_SE0 :
	                    (level_j ^ low_speed) ? usb_line_pkg::LS_FS_J : usb_line_pkg::LS_FS_K;

	a_no_se1: assert property (@(posedge usb_clk) disable iff (usb_rst) !(txp && txm))
		else $error("txp and txm driven high together");

	a_ready_at_boundary: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |-> $past(state == usb_data_pkg::TX_IDLE || (bit_tick && bit_cnt == 3'd7)))
		else $error("tx_ready outside idle or a byte boundary");

endmodule

`default_nettype wire

/* tests/usb_phy_tb.sv */
// testbench for the two-port USB PHY with port A looped back to port B, LFSR payloads and assertions
`default_nettype none
`include "usb_phy_config.svh"

module usb_phy_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 64 * 8 * `USB_LS_DIV * 2 + 4096;

	logic usb_clk;
	logic usb_rst;
	logic port_sel_rx;
	usb_line_pkg::port_mask_t port_sel_tx;
	usb_data_pkg::usb_byte_t tx_data;
	logic tx_valid;
	usb_line_pkg::port_mask_t generate_reset;
	logic tx_low_speed;
	usb_line_pkg::port_mask_t low_speed;
	logic generate_eop;
	wire usb_dp;
	wire usb_dm;
	logic usba_spd;
	logic usba_oe_n;
	logic usbb_spd;
	logic usbb_oe_n;
	usb_line_pkg::line_state_t line_state_a;
	usb_line_pkg::line_state_t line_state_b;
	logic tx_ready;
	logic tx_busy;
	usb_data_pkg::usb_byte_t rx_data;
	logic rx_valid;
	logic rx_active;
	logic rx_error;

	usb_data_pkg::usb_byte_t expected[$];
	logic [31:0] lfsr = 32'ha1e0_5215;
	int errors = 0;
	int checked = 0;
	int cycles = 0;
	int bit_div;
	int run_cycles = 0;
	int se0_cycles = 0;
	usb_line_pkg::line_state_t last_ls = '0;
	logic pkt_se0 = 1'b0;

	// both ports share one cable and the weak pulls leave an idle bus at full-speed J
	pullup pu_dp (usb_dp);
	pulldown pd_dm (usb_dm);

	usb_phy usb_phy_inst (.usb_clk, .usb_rst, .usba_rcv(usb_dp), .usbb_rcv(usb_dp), .port_sel_rx,
		.port_sel_tx, .tx_data, .tx_valid, .generate_reset, .tx_low_speed, .low_speed,
		.generate_eop, .usba_vp(usb_dp), .usba_vm(usb_dm), .usbb_vp(usb_dp), .usbb_vm(usb_dm),
		.usba_spd, .usba_oe_n, .usbb_spd, .usbb_oe_n, .line_state_a, .line_state_b, .tx_ready,
		.tx_busy, .rx_data, .rx_valid, .rx_active, .rx_error);

	assign bit_div = tx_low_speed ? `USB_LS_DIV : `USB_FS_DIV;

	initial begin
		usb_clk = 1'b0;
		forever #50 usb_clk = ~usb_clk;
	end

	// galois LFSR for x^32 + x^22 + x^2 + x + 1 takes one step for every payload bit
	function automatic usb_data_pkg::usb_byte_t random_byte();
		usb_data_pkg::usb_byte_t b;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	// ============================================================
	// line monitors and checks
	// ============================================================

	// how long line_state_b has held its level, and how many SE0 cycles were seen
	always @(posedge usb_clk) begin
		cycles <= cycles + 1;
		run_cycles <= (line_state_b != last_ls) ? 1 : run_cycles + 1;
		last_ls <= line_state_b;
		if (line_state_b == usb_line_pkg::LS_SE0)
			se0_cycles <= se0_cycles + 1;
		if (!rx_active)
			pkt_se0 <= 1'b0;
		else if (line_state_b == usb_line_pkg::LS_SE0)
			pkt_se0 <= 1'b1;
		if (cycles == TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// every strobed byte must match the oldest byte the serializer accepted
	always @(negedge usb_clk) begin
		usb_data_pkg::usb_byte_t want;
		if (!usb_rst && rx_valid) begin
			assert (expected.size() > 0) else begin
				errors++;
				$display("%0t: a byte arrived although none was sent", $time);
			end
			if (expected.size() > 0) begin
				want = expected.pop_front();
				checked++;
				assert (rx_data == want) else begin
					errors++;
					$display("** Error at %0t: rx_data = %02h, expected %02h", $time, rx_data, want);
				end
			end
		end
	end

	a_reset_state: assert property (@(posedge usb_clk) usb_rst |=>
		(usba_oe_n && usbb_oe_n && !tx_busy && !tx_ready && !rx_valid && !rx_active && !rx_error))
		else begin
			errors++;
			$display("%0t: outputs not idle during reset", $time);
		end

	a_no_rx_error: assert property (@(posedge usb_clk) disable iff (usb_rst) !rx_error)
		else begin
			errors++;
			$display("%0t: receiver flagged an error", $time);
		end

	// stuffing keeps any J or K level on the wire to seven bit times at most
	a_stuffed_run: assert property (@(posedge usb_clk) disable iff (usb_rst)
		(rx_active && line_state_b != usb_line_pkg::LS_SE0) |-> run_cycles <= 7 * bit_div)
		else begin
			errors++;
			$display("%0t: line held one level past seven bits", $time);
		end

	a_spd_a: assert property (@(posedge usb_clk) usba_spd == !low_speed[0])
		else begin
			errors++;
			$display("** Error at %0t: usba_spd = %b, expected %b", $time, $sampled(usba_spd),
				!$sampled(low_speed[0]));
		end

	a_spd_b: assert property (@(posedge usb_clk) usbb_spd == !low_speed[1])
		else begin
			errors++;
			$display("** Error at %0t: usbb_spd = %b, expected %b", $time, $sampled(usbb_spd),
				!$sampled(low_speed[1]));
		end

	a_busy_sets: assert property (@(posedge usb_clk) disable iff (usb_rst)
		(tx_valid || generate_eop) |=> tx_busy)
		else begin
			errors++;
			$display("%0t: tx_busy did not set on a request", $time);
		end

	a_eop_order: assert property (@(posedge usb_clk) disable iff (usb_rst)
		$fell(rx_active) |-> pkt_se0)
		else begin
			errors++;
			$display("%0t: packet ended without SE0", $time);
		end

	a_busy_clears_last: assert property (@(posedge usb_clk) disable iff (usb_rst)
		$fell(tx_busy) |-> (usba_oe_n && !rx_active))
		else begin
			errors++;
			$display("%0t: tx_busy fell before the bus was idle", $time);
		end

	a_bus_reset_oe: assert property (@(posedge usb_clk) disable iff (usb_rst)
		generate_reset[0] |-> !usba_oe_n)
		else begin
			errors++;
			$display("** Error at %0t: usba_oe_n = %b, expected 0", $time, $sampled(usba_oe_n));
		end

	a_bus_reset_se0: assert property (@(posedge usb_clk) disable iff (usb_rst)
		generate_reset[0] [*(`USB_FILTER_DEPTH + 1)] |-> line_state_b == usb_line_pkg::LS_SE0)
		else begin
			errors++;
			$display("** Error at %0t: line_state_b = %0d, expected %0d", $time,
				$sampled(line_state_b), usb_line_pkg::LS_SE0);
		end

	// port A watches the same cable through its own filter
	a_bus_reset_se0_a: assert property (@(posedge usb_clk) disable iff (usb_rst)
		generate_reset[0] [*(`USB_FILTER_DEPTH + 1)] |-> line_state_a == usb_line_pkg::LS_SE0)
		else begin
			errors++;
			$display("** Error at %0t: line_state_a = %0d, expected %0d", $time,
				$sampled(line_state_a), usb_line_pkg::LS_SE0);
		end

	a_bus_reset_j: assert property (@(posedge usb_clk) disable iff (usb_rst)
		$fell(generate_reset[0]) |-> ##(`USB_FILTER_DEPTH + 1)
		line_state_b == usb_line_pkg::LS_FS_J)
		else begin
			errors++;
			$display("** Error at %0t: line_state_b = %0d, expected %0d", $time,
				$sampled(line_state_b), usb_line_pkg::LS_FS_J);
		end

	// ============================================================
	// stimulus
	// ============================================================

	// SYNC first, then n payload bytes, each recorded when tx_ready takes it
	task automatic send_packet(input int n, input logic all_ones);
		int sent;
		sent = 0;
		@(negedge usb_clk);
		tx_data = 8'h80;
		tx_valid = 1'b1;
		while (sent <= n) begin
			@(negedge usb_clk);
			if (tx_ready) begin
				if (sent > 0)
					expected.push_back(tx_data);
				sent++;
				if (sent <= n)
					tx_data = all_ones ? 8'hff : random_byte();
				else
					tx_valid = 1'b0;
			end
		end
	endtask

	// wait for the bus to go idle, then every byte must be home and an EOP must have passed
	task automatic finish_packet(input int se0_mark);
		while (tx_busy)
			@(negedge usb_clk);
		repeat (4) @(negedge usb_clk);
		assert (expected.size() == 0) else begin
			errors++;
			$display("%0t: %0d sent bytes never arrived", $time, expected.size());
		end
		assert (se0_cycles - se0_mark >= 2 * bit_div) else begin
			errors++;
			$display("%0t: EOP was shorter than two bit times", $time);
		end
	endtask

	initial begin
		int mark;
		usb_rst = 1'b1;
		port_sel_rx = 1'b1;
		port_sel_tx = 2'b01;
		tx_data = '0;
		tx_valid = 1'b0;
		generate_reset = '0;
		tx_low_speed = 1'b0;
		low_speed = '0;
		generate_eop = 1'b0;
		repeat (3) @(posedge usb_clk);
		@(negedge usb_clk);
		usb_rst = 1'b0;
		repeat (8) @(negedge usb_clk);

		// full-speed random packet, then a packet that needs stuffing everywhere
		mark = se0_cycles;
		send_packet(16, 1'b0);
		finish_packet(mark);
		mark = se0_cycles;
		send_packet(16, 1'b1);
		finish_packet(mark);

		// a bare EOP carries no data
		mark = se0_cycles;
		@(negedge usb_clk);
		generate_eop = 1'b1;
		@(negedge usb_clk);
		generate_eop = 1'b0;
		finish_packet(mark);

		// bus reset on port A is seen through the cable on port B
		generate_reset = 2'b01;
		repeat (12) @(negedge usb_clk);
		generate_reset = '0;
		repeat (12) @(negedge usb_clk);

		// low speed on both ends
		tx_low_speed = 1'b1;
		low_speed = 2'b11;
		repeat (8) @(negedge usb_clk);
		mark = se0_cycles;
		send_packet(8, 1'b0);
		finish_packet(mark);
		repeat (8) @(negedge usb_clk);

		$display("%0d bytes checked, %0d errors", checked, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
